/* list.f */
design/matrix_pkg.sv
design/glyph_pkg.sv
design/scan_if.sv
design/row_scanner.sv
design/glyph_fetch.sv
design/color_stage.sv
design/matrix_display_top.sv
testbench/matrix_display_assert.sv
testbench/matrix_display_tb.sv

/* Bender.yml */
package:
  name: matrix_display

sources:
  # design
  - files:
      - design/matrix_pkg.sv
      - design/glyph_pkg.sv
      - design/scan_if.sv
      - design/row_scanner.sv
      - design/glyph_fetch.sv
      - design/color_stage.sv
      - design/matrix_display_top.sv
  # testbench
  - target: test
    files:
      - testbench/matrix_display_assert.sv
      - testbench/matrix_display_tb.sv

/* testbench/matrix_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_display_tb;

    localparam int          CLK_PERIOD   = 8;
    localparam int          SCAN_DIV_TB  = 4;
    localparam logic [31:0] SEED         = 32'h6fd7;
    localparam int          NUM_TESTS    = 6;
    localparam int          FRAME_CYCLES = matrix_pkg::NUM_ROWS * SCAN_DIV_TB;
    localparam int          WATCHDOG_NS  = NUM_TESTS * 40 * FRAME_CYCLES * CLK_PERIOD + 2000;
    localparam logic [7:0]  ROW0         = 8'hfe;

    logic        clk;
    logic        rst;
    logic        st;
    logic        temp;
    logic [3:0]  num;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic [31:0] rnd_state;
    int          tests_ok;
    int          tests_bad;
    int          fails_before;

    matrix_display_top #(
        .SCAN_DIV (SCAN_DIV_TB)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .temp  (temp),
        .num   (num),
        .row   (row),
        .colg  (colg),
        .colr  (colr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // panel pins looked at on the falling edge
    task automatic wait_row(input int idx);
        @(negedge clk);
        while (row !== ~(8'h01 << idx))
            @(negedge clk);
    endtask

    task automatic wait_frames(input int n);
        repeat (n)
        begin
            while (row === ROW0)
                @(negedge clk);
            while (row !== ROW0)
                @(negedge clk);
        end
    endtask

    task automatic report(input string name);
        int now_fails;
        now_fails = i_dut.i_assert.fail_count;
        if (now_fails == fails_before)
        begin
            tests_ok++;
            $display("%0t %s: done, no assertion failures", $time, name);
        end
        else
        begin
            tests_bad++;
            $display("%0t %s: done, %0d assertion failures", $time, name,
                     now_fails - fails_before);
        end
        fails_before = now_fails;
    endtask

    task automatic run_level_walk();
        for (int lvl = 0; lvl < 16; lvl++)
        begin
            num = lvl[3:0];
            wait_frames(2);
        end
        repeat (16)
        begin
            rnd_state = lcg_next(rnd_state);
            num = rnd_state[19:16];
            wait_frames(2);
        end
    endtask

    task automatic run_alarm();
        repeat (4 * FRAME_CYCLES)
        begin
            @(negedge clk);
            rnd_state = lcg_next(rnd_state);
            temp = rnd_state[23];
            if (rnd_state[27:24] == 4'd0)
                num = rnd_state[19:16];  // now and then a new level too
        end
        @(negedge clk);
        temp = 1'b0;
        wait_frames(1);
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        st = 1'b0;
        temp = 1'b0;
        num = 4'd0;
        rnd_state = SEED;
        tests_ok = 0;
        tests_bad = 0;
        fails_before = 0;

        repeat (4) @(negedge clk);
        rst = 1'b0;
        wait (row !== matrix_pkg::ROW_SEL_IDLE);
        @(negedge clk);
        report("reset_idle");

        st = 1'b1;
        num = 4'd5;
        wait_frames(3);
        report("scan_order");

        run_level_walk();
        report("glyph_content");

        num = 4'd3;
        wait_frames(2);
        wait_row(3);
        num = 4'd8;  // mid frame
        wait_frames(2);
        wait_row(5);
        num = 4'd1;
        wait_frames(2);
        report("frame_sync_level");

        run_alarm();
        report("alarm_colour");

        temp = 1'b1;
        num = 4'd4;
        wait_frames(1);
        wait_row(2);
        st = 1'b0;
        wait_frames(2);
        wait_row(4);
        st = 1'b1;
        wait_frames(2);
        report("enable_blanking");

        $display("summary: %0d tests ok, %0d tests failing", tests_ok, tests_bad);
        if (tests_bad == 0 && i_dut.i_assert.fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/matrix_display_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_display_assert #(
    parameter int SCAN_DIV = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st,
    input  logic                  temp,
    input  glyph_pkg::level_t     num,
    input  matrix_pkg::row_sel_t  row,
    input  matrix_pkg::col_t      colg,
    input  matrix_pkg::col_t      colr
);

    localparam matrix_pkg::row_sel_t ROW0 = {{(matrix_pkg::NUM_ROWS-1){1'b1}}, 1'b0};

    int fail_count = 0;  // read by the testbench

    logic                  st_q1, st_q2, st_q3;
    glyph_pkg::level_t     num_q1, num_q2, num_q3;
    logic                  temp_q;
    matrix_pkg::row_sel_t  row_prev;
    int                    dwell;
    logic                  row0_start;
    glyph_pkg::level_t     level_held, level_now;
    matrix_pkg::col_t      exp_colg;

    function automatic matrix_pkg::col_t glyph_row(input glyph_pkg::level_t lvl,
                                                   input matrix_pkg::row_sel_t rsel);
        int idx;
        idx = -1;
        for (int i = 0; i < matrix_pkg::NUM_ROWS; i++)
            if (!rsel[i])
                idx = i;
        if (idx < 0 || lvl >= glyph_pkg::NUM_GLYPHS)
            return '0;
        return glyph_pkg::GLYPH_TABLE[lvl][idx];
    endfunction

    // inputs seen at the outputs three cycles on
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            {st_q1, st_q2, st_q3} <= '0;
            {num_q1, num_q2, num_q3} <= '0;
            temp_q     <= 1'b0;
            row_prev   <= matrix_pkg::ROW_SEL_IDLE;
            dwell      <= 0;
            level_held <= '0;
        end
        else
        begin
            {st_q1, st_q2, st_q3} <= {st, st_q1, st_q2};
            {num_q1, num_q2, num_q3} <= {num, num_q1, num_q2};
            temp_q     <= temp;
            row_prev   <= row;
            dwell      <= (row != row_prev) ? 1 : dwell + 1;
            level_held <= level_now;
        end
    end

    // row 0 showing up on the pins means the frame began three cycles ago
    assign row0_start = (row == ROW0) && (row_prev != ROW0);

    always_comb
    begin
        if (!st_q3)
            level_now = '0;
        else if (row0_start)
            level_now = num_q3;
        else
            level_now = level_held;
        exp_colg = st_q2 ? glyph_row(level_now, row) : '0;
    end

    a_reset_idle: assert property (@(posedge clk)
        rst |-> (row == matrix_pkg::ROW_SEL_IDLE && colg == '0 && colr == '0))
        else
        begin
            fail_count++;
            $error("ERR %0t row/colg/colr expected %h/00/00 actual %h/%h/%h", $time,
                matrix_pkg::ROW_SEL_IDLE, $sampled(row), $sampled(colg), $sampled(colr));
        end

    a_one_row: assert property (@(posedge clk) disable iff (rst) $onehot0(~row))
        else
        begin
            fail_count++;
            $error("ERR %0t row expected at most one low bit actual %b",
                $time, $sampled(row));
        end

    a_row_step: assert property (@(posedge clk) disable iff (rst)
        (row != row_prev && row_prev != matrix_pkg::ROW_SEL_IDLE)
            |-> row == {row_prev[matrix_pkg::NUM_ROWS-2:0], row_prev[matrix_pkg::NUM_ROWS-1]})
        else
        begin
            fail_count++;
            $error("ERR %0t row expected %h actual %h", $time,
                $sampled({row_prev[matrix_pkg::NUM_ROWS-2:0],
                          row_prev[matrix_pkg::NUM_ROWS-1]}),
                $sampled(row));
        end

    a_row_dwell: assert property (@(posedge clk) disable iff (rst)
        (row != row_prev && row_prev != matrix_pkg::ROW_SEL_IDLE) |-> dwell == SCAN_DIV)
        else
        begin
            fail_count++;
            $error("ERR %0t row dwell expected %0d actual %0d",
                $time, SCAN_DIV, $sampled(dwell));
        end

    a_no_stall: assert property (@(posedge clk) disable iff (rst)
        (row_prev != matrix_pkg::ROW_SEL_IDLE) |-> dwell <= SCAN_DIV)
        else
        begin
            fail_count++;
            $error("row scan stalled on %h", $sampled(row));
        end

    a_green: assert property (@(posedge clk) disable iff (rst) colg == exp_colg)
        else
        begin
            fail_count++;
            $error("ERR %0t colg expected %h actual %h", $time,
                $sampled(exp_colg), $sampled(colg));
        end

    a_red: assert property (@(posedge clk) disable iff (rst)
        colr == (temp_q ? colg : '0))
        else
        begin
            fail_count++;
            $error("ERR %0t colr expected %h actual %h", $time,
                $sampled(temp_q) ? $sampled(colg) : 8'h00, $sampled(colr));
        end

endmodule

bind matrix_display_top matrix_display_assert #(
    .SCAN_DIV (SCAN_DIV)
) i_assert (
    .clk   (clk),
    .rst   (rst),
    .st    (st),
    .temp  (temp),
    .num   (num),
    .row   (row),
    .colg  (colg),
    .colr  (colr)
);

`default_nettype wire

/* design/matrix_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_display_top #(
    parameter int SCAN_DIV = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        st,
    input  logic        temp,
    input  logic [3:0]  num,
    output logic [7:0]  row,
    output logic [7:0]  colg,
    output logic [7:0]  colr
);

    scan_if scan ();

    matrix_pkg::row_sel_t  row_sel_d;
    matrix_pkg::col_t      pattern;
    logic                  blank;

    row_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) i_row_scanner (
        .clk   (clk),
        .rst   (rst),
        .scan  (scan.scanner)
    );

    glyph_fetch i_glyph_fetch (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .num        (num),
        .scan       (scan.fetch),
        .row_sel_d  (row_sel_d),
        .pattern    (pattern),
        .blank      (blank)
    );

    // output register, panel pins
    color_stage i_color_stage (
        .clk        (clk),
        .rst        (rst),
        .temp       (temp),
        .row_sel_d  (row_sel_d),
        .pattern    (pattern),
        .blank      (blank),
        .row        (row),
        .colg       (colg),
        .colr       (colr)
    );

endmodule

`default_nettype wire

/* design/color_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module color_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  temp,
    input  matrix_pkg::row_sel_t  row_sel_d,
    input  matrix_pkg::col_t      pattern,
    input  logic                  blank,
    output matrix_pkg::row_sel_t  row,
    output matrix_pkg::col_t      colg,
    output matrix_pkg::col_t      colr
);

    matrix_pkg::col_t  lit;

    assign lit = blank ? '0 : pattern;

    // all three panel drives switch on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= matrix_pkg::ROW_SEL_IDLE;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel_d;
            colg <= lit;
            colr <= temp ? lit : '0;  // red over green reads amber
        end
    end

endmodule

`default_nettype wire

/* design/glyph_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  st,
    input  glyph_pkg::level_t     num,
    scan_if.fetch                 scan,
    output matrix_pkg::row_sel_t  row_sel_d,
    output matrix_pkg::col_t      pattern,
    output logic                  blank
);

    glyph_pkg::level_t  level;
    matrix_pkg::col_t   glyph_row;

    // level only changes at a frame boundary, so one frame shows one glyph
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            level <= '0;
        else if (!st)
            level <= '0;  // disabled shows level 0
        else if (scan.tick && scan.frame_start)
            level <= num;
    end

    // table lookup, no glyph past the last entry
    always_comb
    begin
        if (level < glyph_pkg::NUM_GLYPHS)
            glyph_row = glyph_pkg::GLYPH_TABLE[level][scan.row_idx];
        else
            glyph_row = '0;
    end

    always_ff @(posedge clk)
    begin
        pattern <= glyph_row;
    end

    // row select and blank ride the same stage as the pattern
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_sel_d <= matrix_pkg::ROW_SEL_IDLE;
            blank     <= 1'b1;
        end
        else
        begin
            row_sel_d <= scan.row_sel;
            blank     <= ~st;
        end
    end

endmodule

`default_nettype wire

/* design/row_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module row_scanner #(
    parameter int SCAN_DIV = 4
) (
    input  logic     clk,
    input  logic     rst,
    scan_if.scanner  scan
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0]      presc;
    matrix_pkg::row_idx_t  row_next;

    // expiry of the prescaler is the row tick
    assign scan.tick = (presc == '0);
    assign scan.frame_start = scan.tick &&
        (scan.row_idx == matrix_pkg::row_idx_t'(matrix_pkg::NUM_ROWS - 1));

    assign row_next = scan.row_idx + 1'b1;  // wraps 7 -> 0

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            presc <= CNT_W'(SCAN_DIV - 1);
        else if (scan.tick)
            presc <= CNT_W'(SCAN_DIV - 1);  // reload
        else
            presc <= presc - 1'b1;
    end

    // row counter and registered decode move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan.row_idx <= '0;
            scan.row_sel <= matrix_pkg::ROW_SEL_IDLE;  // dark until first tick
        end
        else if (scan.tick)
        begin
            scan.row_idx <= row_next;
            scan.row_sel <= ~(matrix_pkg::row_sel_t'(1) << row_next);
        end
    end

endmodule

`default_nettype wire

/* design/scan_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface scan_if;

    logic                  tick;         // row advance strobe
    logic                  frame_start;  // with tick, next row is 0
    matrix_pkg::row_idx_t  row_idx;
    matrix_pkg::row_sel_t  row_sel;      // active low decode of row_idx

    modport scanner (
        output tick,
        output frame_start,
        output row_idx,
        output row_sel
    );

    modport fetch (
        input tick,
        input frame_start,
        input row_idx,
        input row_sel
    );

endinterface

`default_nettype wire

/* design/glyph_pkg.sv */
`default_nettype none

package glyph_pkg;

    typedef logic [3:0] level_t;

    localparam int NUM_GLYPHS = 12;

    // indexed [level][row], row 0 first
    // levels 12..15 have no entry and show blank
    localparam matrix_pkg::col_t GLYPH_TABLE [NUM_GLYPHS][matrix_pkg::NUM_ROWS] = '{
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000},  // 0
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
          8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000},  // 1
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
          8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000},  // 2
        '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
          8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000},  // 3
        '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100},  // 4
        '{8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111},  // 5 full
        // wave patterns
        '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
          8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011},  // 6
        '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
          8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011},  // 7
        '{8'b0000_0000, 8'b0011_1100, 8'b0100_0010, 8'b0100_0010,
          8'b0100_0010, 8'b0100_0010, 8'b0011_1100, 8'b0000_0000},  // 8 ring
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000},  // 9
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000},  // 10
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000}   // 11
    };

endpackage

`default_nettype wire

/* design/matrix_pkg.sv */
`default_nettype none

package matrix_pkg;

    // panel geometry
    localparam int NUM_ROWS = 8;
    localparam int NUM_COLS = 8;

    typedef logic [$clog2(NUM_ROWS)-1:0] row_idx_t;

    // one bit per row, low selects the row
    typedef logic [NUM_ROWS-1:0] row_sel_t;

    // one bit per column, high lights the dot
    typedef logic [NUM_COLS-1:0] col_t;

    localparam row_sel_t ROW_SEL_IDLE = '1;  // no row driven

endpackage

`default_nettype wire
